/* hdl/glb_pkg.sv */
/*
 * Shared widths, depths and enums for the global buffer tile.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package glb_pkg;

    // bank geometry
    localparam int BANK_DATA_WIDTH  = 64;
    localparam int BANK_DATA_BYTE   = 8;
    localparam int GLB_ADDR_WIDTH   = 11;
    localparam int BANK_DEPTH       = 256;
    // word index inside the bank, byte address minus the byte offset
    localparam int BANK_BYTE_OFFSET = $clog2(BANK_DATA_BYTE);
    localparam int BANK_ADDR_WIDTH  = $clog2(BANK_DEPTH);

    // configuration bus, address in the upper half of a bank word
    localparam int CGRA_CFG_ADDR_WIDTH = 32;
    localparam int CGRA_CFG_DATA_WIDTH = 32;

    // register block fields
    localparam int REG_DATA_WIDTH     = 32;
    localparam int MAX_NUM_CFGS_WIDTH = 8;
    localparam int CFG_LATENCY_WIDTH  = 4;

    // taps 0 to 2*15 of the done pulse
    localparam int DONE_DELAY_DEPTH = 31;

    // host register map
    typedef enum logic [2:0] {
        REG_MODE       = 3'd0,
        REG_START_ADDR = 3'd1,
        REG_NUM_CFGS   = 3'd2,
        REG_LATENCY    = 3'd3,
        REG_START      = 3'd4
    } cfg_reg_t;

    // parallel-config dma states
    typedef enum logic [1:0] {
        PC_IDLE  = 2'd0,
        PC_RUN   = 2'd1,
        PC_DRAIN = 2'd2
    } pc_state_t;

endpackage

`default_nettype wire

/* hdl/glb_cfg_regs.sv */
/*
 * Host-written configuration registers of the tile.
 * Holds the dma header, mode and latency; a REG_START write
 * gives a one-cycle start strobe on the following cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_cfg_regs import glb_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          reg_wr_en,
    input  wire cfg_reg_t                      reg_addr,
    input  wire logic [REG_DATA_WIDTH-1:0]     reg_wr_data,
    output logic                               cfg_pc_dma_mode,
    output logic [GLB_ADDR_WIDTH-1:0]          cfg_start_addr,
    output logic [MAX_NUM_CFGS_WIDTH-1:0]      cfg_num_cfgs,
    output logic [CFG_LATENCY_WIDTH-1:0]       cfg_pc_latency,
    output logic                               pc_start_pulse
);

    // register decode, one field per address
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_pc_dma_mode <= 1'b0;
            cfg_start_addr  <= '0;
            cfg_num_cfgs    <= '0;
            cfg_pc_latency  <= '0;
        end else if (reg_wr_en) begin
            case (reg_addr)
                REG_MODE:       cfg_pc_dma_mode <= reg_wr_data[0];
                REG_START_ADDR: cfg_start_addr  <= reg_wr_data[GLB_ADDR_WIDTH-1:0];
                REG_NUM_CFGS:   cfg_num_cfgs    <= reg_wr_data[MAX_NUM_CFGS_WIDTH-1:0];
                REG_LATENCY:    cfg_pc_latency  <= reg_wr_data[CFG_LATENCY_WIDTH-1:0];
                // start has no storage, see strobe below
                default: ;
            endcase
        end
    end

    // start strobe, data value ignored
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_start_pulse <= 1'b0;
        end else begin
            pc_start_pulse <= reg_wr_en && (reg_addr == REG_START);
        end
    end

endmodule

`default_nettype wire

/* hdl/glb_host_port.sv */
/*
 * Host memory port of the tile.
 * Turns host strobes into one bank request per cycle and returns
 * read data, holding the last host word while the dma uses the bus.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_host_port import glb_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        mem_wr_en,
    input  wire logic                        mem_rd_en,
    input  wire logic [GLB_ADDR_WIDTH-1:0]   mem_addr,
    input  wire logic [BANK_DATA_WIDTH-1:0]  mem_wr_data,
    output logic [BANK_DATA_WIDTH-1:0]       mem_rd_data,
    output logic                             mem_rd_data_valid,
    output logic                             host_req,
    output logic                             host_wr,
    output logic [GLB_ADDR_WIDTH-1:0]        host_addr,
    output logic [BANK_DATA_WIDTH-1:0]       host_wr_data,
    input  wire logic                        host_rd_data_valid,
    input  wire logic [BANK_DATA_WIDTH-1:0]  bank_rd_data
);

    logic [BANK_DATA_WIDTH-1:0] rd_data_hold;

    // one request per cycle
    // write wins, a read in the same cycle is dropped
    assign host_req     = mem_wr_en | mem_rd_en;
    assign host_wr      = mem_wr_en;
    assign host_addr    = mem_addr;
    assign host_wr_data = mem_wr_data;

    // keep the last host word once the response is gone
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_hold <= '0;
        end else if (host_rd_data_valid) begin
            rd_data_hold <= bank_rd_data;
        end
    end

    // shared bank data only passes through with our own valid
    assign mem_rd_data_valid = host_rd_data_valid;
    assign mem_rd_data       = host_rd_data_valid ? bank_rd_data : rd_data_hold;

endmodule

`default_nettype wire

/* hdl/glb_bank_arbiter.sv */
/*
 * Fixed-priority arbiter between the host port and the pc dma.
 * Drives the single bank port and steers each read response back
 * to the requester that issued it one cycle earlier.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_bank_arbiter import glb_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        host_req,
    input  wire logic                        host_wr,
    input  wire logic [GLB_ADDR_WIDTH-1:0]   host_addr,
    input  wire logic [BANK_DATA_WIDTH-1:0]  host_wr_data,
    input  wire logic                        dma_req,
    input  wire logic [GLB_ADDR_WIDTH-1:0]   dma_addr,
    output logic                             dma_gnt,
    output logic                             host_rd_data_valid,
    output logic                             dma_rd_data_valid,
    output logic                             bank_wr_en,
    output logic                             bank_rd_en,
    output logic [BANK_ADDR_WIDTH-1:0]       bank_addr,
    output logic [BANK_DATA_WIDTH-1:0]       bank_wr_data,
    input  wire logic                        bank_rd_data_valid
);

    logic [GLB_ADDR_WIDTH-1:0] sel_addr;
    logic                      rd_owner_dma;

    // host always wins, it has no grant of its own
    assign dma_gnt = dma_req & ~host_req;

    // mux the winner onto the bank
    always_comb begin
        if (host_req) begin
            bank_wr_en = host_wr;
            bank_rd_en = ~host_wr;
            sel_addr   = host_addr;
        end else begin
            // the dma only ever reads
            bank_wr_en = 1'b0;
            bank_rd_en = dma_req;
            sel_addr   = dma_addr;
        end
    end

    // byte address to word index
    assign bank_addr    = sel_addr[GLB_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
    assign bank_wr_data = host_wr_data;

    // owner of the read now in the bank
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_owner_dma <= 1'b0;
        end else if (bank_rd_en) begin
            rd_owner_dma <= ~host_req;
        end
    end

    // response routing, data bus is shared
    assign host_rd_data_valid = bank_rd_data_valid & ~rd_owner_dma;
    assign dma_rd_data_valid  = bank_rd_data_valid & rd_owner_dma;

endmodule

`default_nettype wire

/* hdl/glb_bank.sv */
/*
 * Single-port memory bank of the tile.
 * Write and read share one port; read data and its valid strobe
 * come out one cycle after rd_en.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_bank import glb_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        wr_en,
    input  wire logic                        rd_en,
    input  wire logic [BANK_ADDR_WIDTH-1:0]  addr,
    input  wire logic [BANK_DATA_WIDTH-1:0]  wr_data,
    output logic [BANK_DATA_WIDTH-1:0]       rd_data,
    output logic                             rd_data_valid
);

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    // storage and registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

    // valid follows rd_en by one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

/* hdl/glb_pc_dma.sv */
/*
 * Parallel-configuration dma of the tile.
 * Reads a block of bank words through the arbiter and writes each
 * one to the configuration bus, then pulses done.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_pc_dma import glb_pkg::*; (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           cfg_pc_dma_mode,
    input  wire logic [GLB_ADDR_WIDTH-1:0]      cfg_start_addr,
    input  wire logic [MAX_NUM_CFGS_WIDTH-1:0]  cfg_num_cfgs,
    input  wire logic                           pc_start_pulse,
    output logic                                dma_req,
    output logic [GLB_ADDR_WIDTH-1:0]           dma_addr,
    input  wire logic                           dma_gnt,
    input  wire logic                           dma_rd_data_valid,
    input  wire logic [BANK_DATA_WIDTH-1:0]     bank_rd_data,
    output logic                                cgra_cfg_wr_en,
    output logic [CGRA_CFG_ADDR_WIDTH-1:0]      cgra_cfg_addr,
    output logic [CGRA_CFG_DATA_WIDTH-1:0]      cgra_cfg_data,
    output logic                                done_pulse_internal
);

    pc_state_t                     state;
    logic                          start_pulse_internal;
    logic [MAX_NUM_CFGS_WIDTH-1:0] cfg_cnt;
    logic [GLB_ADDR_WIDTH-1:0]     addr_q;
    // reads granted but not yet answered
    logic [1:0]                    pend_cnt;
    logic [BANK_DATA_WIDTH-1:0]    rd_data_q;

    // start only counts when idle and enabled
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_pulse_internal <= 1'b0;
        end else begin
            start_pulse_internal <= pc_start_pulse & cfg_pc_dma_mode & (state == PC_IDLE);
        end
    end

    // request held with its address until granted
    assign dma_req  = (state == PC_RUN);
    assign dma_addr = addr_q;

    // main fsm with word counter and address
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= PC_IDLE;
            cfg_cnt <= '0;
            addr_q  <= '0;
        end else begin
            case (state)
                PC_IDLE: begin
                    if (start_pulse_internal) begin
                        cfg_cnt <= cfg_num_cfgs;
                        addr_q  <= cfg_start_addr;
                        // empty header skips straight to done
                        state   <= (cfg_num_cfgs == '0) ? PC_DRAIN : PC_RUN;
                    end
                end
                PC_RUN: begin
                    if (dma_gnt) begin
                        cfg_cnt <= cfg_cnt - 1'b1;
                        addr_q  <= addr_q + GLB_ADDR_WIDTH'(BANK_DATA_BYTE);
                        if (cfg_cnt == 1) begin
                            state <= PC_DRAIN;
                        end
                    end
                end
                PC_DRAIN: begin
                    if (pend_cnt == '0) begin
                        state <= PC_IDLE;
                    end
                end
                default: state <= PC_IDLE;
            endcase
        end
    end

    // outstanding read count, at most one in flight per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pend_cnt <= '0;
        end else begin
            case ({dma_gnt, dma_rd_data_valid})
                2'b10:   pend_cnt <= pend_cnt + 1'b1;
                2'b01:   pend_cnt <= pend_cnt - 1'b1;
                default: ;
            endcase
        end
    end

    // done lands the cycle after the last bus write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_pulse_internal <= 1'b0;
        end else begin
            done_pulse_internal <= (state == PC_DRAIN) && (pend_cnt == '0);
        end
    end

    // response word register
    always_ff @(posedge clk) begin
        if (dma_rd_data_valid) begin
            rd_data_q <= bank_rd_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cgra_cfg_wr_en <= 1'b0;
        end else begin
            cgra_cfg_wr_en <= dma_rd_data_valid;
        end
    end

    // upper half is the config address
    assign cgra_cfg_addr = rd_data_q[CGRA_CFG_DATA_WIDTH +: CGRA_CFG_ADDR_WIDTH];
    assign cgra_cfg_data = rd_data_q[0 +: CGRA_CFG_DATA_WIDTH];

endmodule

`default_nettype wire

/* hdl/glb_done_delay.sv */
/*
 * Delay line for the dma done pulse.
 * Models the tile chain, output taken at tap 2*cfg_pc_latency;
 * tap 0 passes the input straight through.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_done_delay import glb_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          done_in,
    input  wire logic [CFG_LATENCY_WIDTH-1:0]  cfg_pc_latency,
    output logic                               pc_done_pulse
);

    // taps[k] is done_in delayed by k cycles
    logic [DONE_DELAY_DEPTH-1:0] taps;
    logic [CFG_LATENCY_WIDTH:0]  tap_sel;

    assign taps[0] = done_in;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            taps[DONE_DELAY_DEPTH-1:1] <= '0;
        end else begin
            taps[DONE_DELAY_DEPTH-1:1] <= taps[DONE_DELAY_DEPTH-2:0];
        end
    end

    // two stages per modelled tile
    assign tap_sel       = {cfg_pc_latency, 1'b0};
    assign pc_done_pulse = taps[tap_sel];

endmodule

`default_nettype wire

/* hdl/glb_tile.sv */
/*
 * Top level of one global buffer tile.
 * Connects the register block, host port, pc dma, arbiter,
 * bank and done delay line.
 */
`timescale 1ns/100ps
`default_nettype none

module glb_tile import glb_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        reset,
    // host registers
    input  wire logic                        reg_wr_en,
    input  wire cfg_reg_t                    reg_addr,
    input  wire logic [REG_DATA_WIDTH-1:0]   reg_wr_data,
    // host memory
    input  wire logic                        mem_wr_en,
    input  wire logic                        mem_rd_en,
    input  wire logic [GLB_ADDR_WIDTH-1:0]   mem_addr,
    input  wire logic [BANK_DATA_WIDTH-1:0]  mem_wr_data,
    output logic [BANK_DATA_WIDTH-1:0]       mem_rd_data,
    output logic                             mem_rd_data_valid,
    // configuration bus
    output logic                             cgra_cfg_wr_en,
    output logic [CGRA_CFG_ADDR_WIDTH-1:0]   cgra_cfg_addr,
    output logic [CGRA_CFG_DATA_WIDTH-1:0]   cgra_cfg_data,
    output logic                             pc_done_pulse
);

    logic                          cfg_pc_dma_mode;
    logic [GLB_ADDR_WIDTH-1:0]     cfg_start_addr;
    logic [MAX_NUM_CFGS_WIDTH-1:0] cfg_num_cfgs;
    logic [CFG_LATENCY_WIDTH-1:0]  cfg_pc_latency;
    logic                          pc_start_pulse;
    logic                          done_pulse_internal;
    // host side
    logic                          host_req;
    logic                          host_wr;
    logic [GLB_ADDR_WIDTH-1:0]     host_addr;
    logic [BANK_DATA_WIDTH-1:0]    host_wr_data;
    logic                          host_rd_data_valid;
    // dma side
    logic                          dma_req;
    logic [GLB_ADDR_WIDTH-1:0]     dma_addr;
    logic                          dma_gnt;
    logic                          dma_rd_data_valid;
    // bank port
    logic                          bank_wr_en;
    logic                          bank_rd_en;
    logic [BANK_ADDR_WIDTH-1:0]    bank_addr;
    logic [BANK_DATA_WIDTH-1:0]    bank_wr_data;
    logic [BANK_DATA_WIDTH-1:0]    bank_rd_data;
    logic                          bank_rd_data_valid;

    glb_cfg_regs cfg_regs_i (.*);

    glb_host_port host_port_i (.*);

    glb_pc_dma pc_dma_i (.*);

    glb_bank_arbiter arbiter_i (.*);

    glb_bank bank_i (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (bank_wr_en),
        .rd_en         (bank_rd_en),
        .addr          (bank_addr),
        .wr_data       (bank_wr_data),
        .rd_data       (bank_rd_data),
        .rd_data_valid (bank_rd_data_valid)
    );

    glb_done_delay done_delay_i (
        .clk            (clk),
        .reset          (reset),
        .done_in        (done_pulse_internal),
        .cfg_pc_latency (cfg_pc_latency),
        .pc_done_pulse  (pc_done_pulse)
    );

endmodule

`default_nettype wire

/* testbench/tb_glb_tile.sv */
/*
 * Directed testbench for the global buffer tile.
 * Covers host access, the config DMA stream, done delay,
 * back-pressure from host reads, ignored starts and empty headers.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_glb_tile import glb_pkg::*; ();

    logic                           clk;
    logic                           reset;
    logic                           reg_wr_en;
    cfg_reg_t                       reg_addr;
    logic [REG_DATA_WIDTH-1:0]      reg_wr_data;
    logic                           mem_wr_en;
    logic                           mem_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]      mem_addr;
    logic [BANK_DATA_WIDTH-1:0]     mem_wr_data;
    logic [BANK_DATA_WIDTH-1:0]     mem_rd_data;
    logic                           mem_rd_data_valid;
    logic                           cgra_cfg_wr_en;
    logic [CGRA_CFG_ADDR_WIDTH-1:0] cgra_cfg_addr;
    logic [CGRA_CFG_DATA_WIDTH-1:0] cgra_cfg_data;
    logic                           pc_done_pulse;

    // bank contents as the testbench wrote them
    logic [BANK_DATA_WIDTH-1:0] model [BANK_DEPTH];
    // expected config words in arrival order
    logic [BANK_DATA_WIDTH-1:0] exp_q [$];
    logic [BANK_DATA_WIDTH-1:0] exp_word;
    integer seed;
    string  cur_test;
    int     cycle_cnt;
    int     beat_cnt;
    int     done_cnt;
    int     last_beat_cycle;
    int     done_cycle;
    int     run_beats0;
    int     run_done0;

    glb_tile dut_i (.*);

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check(input string label, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s %s expected %h actual %h",
                               cur_test, label, expected, actual));
        end
    endtask

    // config bus monitor samples before the edge updates
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!reset && cgra_cfg_wr_en) begin
            if (exp_q.size() == 0) begin
                fail_run($sformatf("%s: configuration beat with nothing expected", cur_test));
            end else begin
                exp_word = exp_q.pop_front();
                check("cfg_addr", exp_word[63:32], cgra_cfg_addr);
                check("cfg_data", exp_word[31:0], cgra_cfg_data);
                beat_cnt        = beat_cnt + 1;
                last_beat_cycle = cycle_cnt;
            end
        end
        if (!reset && pc_done_pulse) begin
            done_cnt   = done_cnt + 1;
            done_cycle = cycle_cnt;
        end
    end

    task automatic reg_write(input cfg_reg_t addr, input logic [31:0] data);
        @(negedge clk);
        reg_wr_en   = 1'b1;
        reg_addr    = addr;
        reg_wr_data = data;
        @(negedge clk);
        reg_wr_en   = 1'b0;
    endtask

    task automatic mem_write(input int idx, input logic [63:0] data);
        @(negedge clk);
        mem_wr_en   = 1'b1;
        mem_addr    = GLB_ADDR_WIDTH'(idx * BANK_DATA_BYTE);
        mem_wr_data = data;
        model[idx]  = data;
        @(negedge clk);
        mem_wr_en   = 1'b0;
    endtask

    // n random words from word index base upward
    task automatic fill_block(input int base, input int n);
        logic [63:0] w;
        for (int i = 0; i < n; i++) begin
            w[63:32] = $random(seed);
            w[31:0]  = $random(seed);
            mem_write(base + i, w);
        end
    endtask

    // back-to-back reads each answered on the next cycle
    task automatic read_check(input int base, input int n);
        for (int i = 0; i <= n; i++) begin
            @(negedge clk);
            if (i == 0) begin
                // no host read on the edge before, a dma response must stay off the host
                check("rd_valid_idle", 64'd0, {63'd0, mem_rd_data_valid});
            end else begin
                check("rd_valid", 64'd1, {63'd0, mem_rd_data_valid});
                check("rd_data", model[base + i - 1], mem_rd_data);
            end
            if (i < n) begin
                mem_rd_en = 1'b1;
                mem_addr  = GLB_ADDR_WIDTH'((base + i) * BANK_DATA_BYTE);
            end else begin
                mem_rd_en = 1'b0;
            end
        end
    endtask

    task automatic start_dma(input int base, input int n, input int lat);
        run_beats0 = beat_cnt;
        run_done0  = done_cnt;
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(model[base + i]);
        end
        reg_write(REG_START_ADDR, 32'(base * BANK_DATA_BYTE));
        reg_write(REG_NUM_CFGS, 32'(n));
        reg_write(REG_LATENCY, 32'(lat));
        reg_write(REG_MODE, 32'd1);
        reg_write(REG_START, 32'd1);
    endtask

    task automatic finish_dma(input int n, input bit check_delay, input int lat);
        int i;
        i = 0;
        while (done_cnt == run_done0 && i < 2000) begin
            @(negedge clk);
            i++;
        end
        if (done_cnt == run_done0) begin
            fail_run($sformatf("%s: timed out waiting for pc_done_pulse", cur_test));
        end
        check("beats", 64'(n), 64'(beat_cnt - run_beats0));
        if (check_delay) begin
            check("done_delay", 64'(2 * lat + 1), 64'(done_cycle - last_beat_cycle));
        end
    endtask

    // no done pulse may appear here and the monitor rejects any stray beat
    task automatic quiet_window(input int cycles);
        int done0;
        done0 = done_cnt;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
        end
        check("quiet_done", 64'(done0), 64'(done_cnt));
    endtask

    initial begin
        seed        = 32'hfb1c0ffe;
        clk         = 1'b0;
        reset       = 1'b1;
        reg_wr_en   = 1'b0;
        reg_addr    = REG_MODE;
        reg_wr_data = '0;
        mem_wr_en   = 1'b0;
        mem_rd_en   = 1'b0;
        mem_addr    = '0;
        mem_wr_data = '0;
        cycle_cnt   = 0;
        beat_cnt    = 0;
        done_cnt    = 0;
        cur_test    = "reset";
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cur_test = "host_rw";
        fill_block(16, 8);
        read_check(16, 8);
        read_check(20, 1);

        // stream with no host traffic at two latencies
        cur_test = "stream_lat0";
        fill_block(32, 6);
        start_dma(32, 6, 0);
        finish_dma(6, 1, 0);
        cur_test = "stream_lat5";
        fill_block(64, 10);
        start_dma(64, 10, 5);
        finish_dma(10, 1, 5);

        // host bursts leave one free cycle between them
        cur_test = "back_pressure";
        fill_block(100, 12);
        start_dma(100, 12, 2);
        for (int k = 0; k < 8; k++) begin
            read_check(100 + k, 3);
        end
        finish_dma(12, 0, 2);

        cur_test = "start_mode_off";
        reg_write(REG_MODE, 32'd0);
        reg_write(REG_START, 32'd1);
        quiet_window(60);

        // second start lands while the first run is busy
        cur_test = "start_in_run";
        start_dma(32, 6, 1);
        repeat (4) @(negedge clk);
        reg_write(REG_START, 32'd1);
        finish_dma(6, 1, 1);
        quiet_window(60);

        cur_test = "zero_length";
        start_dma(40, 0, 0);
        finish_dma(0, 0, 0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/glb_pkg.sv
hdl/glb_cfg_regs.sv
hdl/glb_host_port.sv
hdl/glb_bank_arbiter.sv
hdl/glb_bank.sv
hdl/glb_pc_dma.sv
hdl/glb_done_delay.sv
hdl/glb_tile.sv
testbench/tb_glb_tile.sv
